// ==== logic/backend_pkg.sv ====
// Shared widths, word types and the writeback instruction kind for the back end
// Every RTL module and the testbench import this package by wildcard in the module header
`default_nettype none

package backend_pkg;

  // Width of a data word, a register and a byte address
  localparam int unsigned XLEN = 32;

  // Width of a register index
  localparam int unsigned REG_ADDR_W = 5;

  // Number of architectural registers, x0 included
  localparam int unsigned NUM_REGS = 2 ** REG_ADDR_W;

  // Register value, load data, store data or a finished result
  typedef logic [XLEN-1:0] data_t;

  // Byte address on the bus and program counter of an instruction
  typedef logic [XLEN-1:0] addr_t;

  // Index into the register file
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // What an instruction waits for once it sits in writeback
  // OTHER retires at once, LOAD and STORE wait for the bus acknowledge
  typedef enum logic [1:0] {
    WB_INSTR_OTHER = 2'b00,
    WB_INSTR_LOAD  = 2'b01,
    WB_INSTR_STORE = 2'b10
  } wb_instr_type_e;

endpackage

`default_nettype wire

// ==== logic/ex_wb_if.sv ====
// Issued instruction as it crosses from the issue boundary into writeback and the LSU
// The top level drives it, the writeback stage and the LSU each read their own view
`timescale 1ns/1ps
`default_nettype none

interface ex_wb_if import backend_pkg::*; ();

  // Accept strobe, already qualified with the stage's ready
  logic           en;
  wb_instr_type_e instr_type;
  addr_t          pc;
  reg_addr_t      rf_waddr;
  data_t          rf_wdata;
  logic           rf_we;
  // Only meaningful for loads and stores
  addr_t          mem_addr;
  data_t          mem_wdata;

  modport issuer (
    output en, instr_type, pc, rf_waddr, rf_wdata, rf_we, mem_addr, mem_wdata
  );

  modport stage (
    input en, instr_type, pc, rf_waddr, rf_wdata, rf_we, mem_addr, mem_wdata
  );

  // The LSU only needs the memory part of the instruction
  modport lsu (
    input en, instr_type, mem_addr, mem_wdata
  );

endinterface

`default_nettype wire

// ==== logic/lsu_wishbone.sv ====
// Load/store unit that turns each accepted load or store into one Wishbone classic cycle
// Load data and a completion pulse go straight to the writeback stage on the ack cycle
`timescale 1ns/1ps
`default_nettype none

module lsu_wishbone import backend_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  ex_wb_if.lsu              ex_i,

  // Wishbone classic master
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output addr_t             wb_adr_o,
  output data_t             wb_dat_o,
  output logic [XLEN/8-1:0] wb_sel_o,
  input  data_t             wb_dat_i,
  input  logic              wb_ack_i,

  // Towards the writeback stage
  output data_t             rdata_o,
  output logic              rf_we_o,
  output logic              data_valid_o
);

  typedef enum logic {
    LSU_IDLE,
    LSU_BUS
  } lsu_state_e;

  lsu_state_e state_q;
  lsu_state_e state_d;

  // Bus request captured on acceptance and held for the whole cycle
  addr_t adr_q;
  data_t dat_q;
  logic  we_q;

  logic  mem_req;
  logic  bus_ack;

  // A memory instruction is accepted this cycle
  assign mem_req = ex_i.en & ((ex_i.instr_type == WB_INSTR_LOAD) |
                              (ex_i.instr_type == WB_INSTR_STORE));

  // The ack only counts while a cycle is actually open
  assign bus_ack = (state_q == LSU_BUS) & wb_ack_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      LSU_IDLE: begin
        if (mem_req) begin
          state_d = LSU_BUS;
        end
      end
      LSU_BUS: begin
        // A new access can only be accepted in the ack cycle, since ready is low before it
        if (bus_ack) begin
          state_d = mem_req ? LSU_BUS : LSU_IDLE;
        end
      end
      default: state_d = LSU_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= LSU_IDLE;
      adr_q   <= '0;
      dat_q   <= '0;
      we_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (mem_req) begin
        // Word accesses only, so the byte offset is dropped
        adr_q <= {ex_i.mem_addr[XLEN-1:2], 2'b00};
        dat_q <= ex_i.mem_wdata;
        we_q  <= (ex_i.instr_type == WB_INSTR_STORE);
      end
    end
  end

  // Cyc and stb rise and fall together for the whole access
  assign wb_cyc_o = (state_q == LSU_BUS);
  assign wb_stb_o = (state_q == LSU_BUS);
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_dat_o = dat_q;
  assign wb_sel_o = '1;

  // Read data is passed through on the ack cycle, only loads write the register file
  assign rdata_o      = wb_dat_i;
  assign data_valid_o = bus_ack;
  assign rf_we_o      = bus_ack & ~we_q;

endmodule

`default_nettype wire

// ==== logic/wb_stage.sv ====
// Registered writeback stage holding one instruction until it completes
// Merges the issued result and the LSU load data into one register-file write port
`timescale 1ns/1ps
`default_nettype none

module wb_stage import backend_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  ex_wb_if.stage    ex_i,

  // Load/store completion from the LSU
  input  data_t     lsu_rdata_i,
  input  logic      lsu_rf_we_i,
  input  logic      lsu_data_valid_i,

  // Issue side and status
  output logic      ready_o,
  output logic      instr_done_o,
  output addr_t     pc_wb_o,
  output logic      outstanding_load_o,
  output logic      outstanding_store_o,

  // Register-file write port
  output reg_addr_t rf_waddr_o,
  output data_t     rf_wdata_o,
  output logic      rf_we_o
);

  // Occupancy of the single stage slot
  logic           valid_q;
  logic           valid_d;
  logic           done;

  // Copy of the instruction taken on acceptance
  wb_instr_type_e type_q;
  addr_t          pc_q;
  reg_addr_t      waddr_q;
  data_t          wdata_q;
  logic           we_q;

  // Write from the stored result rather than from the LSU
  logic           stage_we;

  // Plain instructions finish in their first cycle, memory ones wait for the LSU
  // Only meaningful while valid_q is set
  assign done = (type_q == WB_INSTR_OTHER) | lsu_data_valid_i;

  // A new instruction enters when the slot is empty or being vacated this cycle
  assign ready_o = ~valid_q | done;

  // The slot stays full if a new instruction enters as the old one retires
  assign valid_d = ex_i.en | (valid_q & ~done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      type_q  <= WB_INSTR_OTHER;
      pc_q    <= '0;
      waddr_q <= '0;
      wdata_q <= '0;
      we_q    <= 1'b0;
    end else begin
      valid_q <= valid_d;
      if (ex_i.en) begin
        type_q  <= ex_i.instr_type;
        pc_q    <= ex_i.pc;
        waddr_q <= ex_i.rf_waddr;
        wdata_q <= ex_i.rf_wdata;
        we_q    <= ex_i.rf_we;
      end
    end
  end

  assign instr_done_o = valid_q & done;
  assign pc_wb_o      = pc_q;

  // Status flags hold from the first cycle of occupancy up to and including the ack cycle
  assign outstanding_load_o  = valid_q & (type_q == WB_INSTR_LOAD);
  assign outstanding_store_o = valid_q & (type_q == WB_INSTR_STORE);

  // Loads and stores never write the stored result, which keeps the two sources exclusive
  assign stage_we = valid_q & we_q & (type_q == WB_INSTR_OTHER);

  // A load's destination is the stored index as well, so one address serves both sources
  assign rf_waddr_o = waddr_q;
  assign rf_wdata_o = stage_we ? wdata_q : lsu_rdata_i;
  assign rf_we_o    = stage_we | lsu_rf_we_i;

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
// Register file with 32 entries, one write port and one combinational read port
// Index 0 is hardwired to zero and writes to it are dropped
`timescale 1ns/1ps
`default_nettype none

module reg_file import backend_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  // Write port, taken at the rising edge
  input  logic      we_i,
  input  reg_addr_t waddr_i,
  input  data_t     wdata_i,

  // Read port, visible the edge after a write
  input  reg_addr_t raddr_i,
  output data_t     rdata_o
);

  // x0 has no storage
  data_t regs_q [1:NUM_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Reads of x0 return zero without touching the array
  assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

endmodule

`default_nettype wire

// ==== logic/backend_top.sv ====
// Top level of the back end with plain issue, Wishbone, status and observation ports
// Feeds the issue ports into the shared instruction bundle and wires up the three blocks
`timescale 1ns/1ps
`default_nettype none

module backend_top import backend_pkg::*; (
  input  logic              clk_i,
  input  logic              rst_ni,

  // Issue handshake, inputs sampled only on acceptance
  input  logic              issue_valid_i,
  output logic              issue_ready_o,
  input  wb_instr_type_e    issue_type_i,
  input  addr_t             issue_pc_i,
  input  reg_addr_t         issue_rd_i,
  input  data_t             issue_result_i,
  input  logic              issue_rd_we_i,
  input  addr_t             issue_addr_i,
  input  data_t             issue_store_data_i,

  // Wishbone classic master
  output logic              wb_cyc_o,
  output logic              wb_stb_o,
  output logic              wb_we_o,
  output addr_t             wb_adr_o,
  output data_t             wb_dat_o,
  output logic [XLEN/8-1:0] wb_sel_o,
  input  data_t             wb_dat_i,
  input  logic              wb_ack_i,

  // Retirement status
  output logic              instr_done_o,
  output addr_t             pc_wb_o,
  output logic              outstanding_load_o,
  output logic              outstanding_store_o,

  // Register observation port
  input  reg_addr_t         rf_raddr_i,
  output data_t             rf_rdata_o
);

  ex_wb_if ex_wb ();

  logic      stage_ready;
  data_t     lsu_rdata;
  logic      lsu_rf_we;
  logic      lsu_data_valid;
  reg_addr_t rf_waddr;
  data_t     rf_wdata;
  logic      rf_we;

  // The accept strobe is formed here once, both consumers see the same event
  assign ex_wb.en         = issue_valid_i & stage_ready;
  assign ex_wb.instr_type = issue_type_i;
  assign ex_wb.pc         = issue_pc_i;
  assign ex_wb.rf_waddr   = issue_rd_i;
  assign ex_wb.rf_wdata   = issue_result_i;
  assign ex_wb.rf_we      = issue_rd_we_i;
  assign ex_wb.mem_addr   = issue_addr_i;
  assign ex_wb.mem_wdata  = issue_store_data_i;

  assign issue_ready_o = stage_ready;

  lsu_wishbone u_lsu (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .ex_i         (ex_wb.lsu),
    .wb_cyc_o     (wb_cyc_o),
    .wb_stb_o     (wb_stb_o),
    .wb_we_o      (wb_we_o),
    .wb_adr_o     (wb_adr_o),
    .wb_dat_o     (wb_dat_o),
    .wb_sel_o     (wb_sel_o),
    .wb_dat_i     (wb_dat_i),
    .wb_ack_i     (wb_ack_i),
    .rdata_o      (lsu_rdata),
    .rf_we_o      (lsu_rf_we),
    .data_valid_o (lsu_data_valid)
  );

  wb_stage u_wb_stage (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ex_i                (ex_wb.stage),
    .lsu_rdata_i         (lsu_rdata),
    .lsu_rf_we_i         (lsu_rf_we),
    .lsu_data_valid_i    (lsu_data_valid),
    .ready_o             (stage_ready),
    .instr_done_o        (instr_done_o),
    .pc_wb_o             (pc_wb_o),
    .outstanding_load_o  (outstanding_load_o),
    .outstanding_store_o (outstanding_store_o),
    .rf_waddr_o          (rf_waddr),
    .rf_wdata_o          (rf_wdata),
    .rf_we_o             (rf_we)
  );

  reg_file u_reg_file (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .we_i    (rf_we),
    .waddr_i (rf_waddr),
    .wdata_i (rf_wdata),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

endmodule

`default_nettype wire

// ==== testbench/backend_assertions.sv ====
// Concurrent checks on the writeback stage and the Wishbone master, attached by bind
// Each instance ties the ports of the block it does not watch to zero
`timescale 1ns/1ps
`default_nettype none

module backend_assertions import backend_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  // Writeback stage view
  input logic  stage_we_i,
  input logic  lsu_we_i,
  input logic  done_i,
  input logic  occupied_i,
  // Wishbone master view
  input logic  cyc_i,
  input logic  stb_i,
  input logic  ack_i,
  input logic  we_i,
  input addr_t adr_i,
  input data_t dat_i
);

  // The stored result and the load data never share a write cycle
  write_sources_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(stage_we_i && lsu_we_i)
  ) else $error("stored result and load data wrote the register file together");

  // The request holds still until the ack is seen
  request_held_until_ack: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (stb_i && !ack_i) |=> (cyc_i && stb_i && $stable(adr_i) && $stable(dat_i) && $stable(we_i))
  ) else $error("Wishbone request changed or dropped before ack");

  // The LSU only completes an access that the writeback stage is waiting for
  done_needs_occupant: assert property (
    @(posedge clk_i) disable iff (!rst_ni) done_i |-> occupied_i
  ) else $error("LSU completion with no load or store in the writeback stage");

endmodule

bind wb_stage backend_assertions u_stage_assertions (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .stage_we_i (stage_we),
  .lsu_we_i   (lsu_rf_we_i),
  .done_i     (lsu_data_valid_i),
  .occupied_i (outstanding_load_o | outstanding_store_o),
  .cyc_i      (1'b0),
  .stb_i      (1'b0),
  .ack_i      (1'b0),
  .we_i       (1'b0),
  .adr_i      ('0),
  .dat_i      ('0)
);

bind lsu_wishbone backend_assertions u_bus_assertions (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .stage_we_i (1'b0),
  .lsu_we_i   (1'b0),
  .done_i     (1'b0),
  .occupied_i (1'b0),
  .cyc_i      (wb_cyc_o),
  .stb_i      (wb_stb_o),
  .ack_i      (wb_ack_i),
  .we_i       (wb_we_o),
  .adr_i      (wb_adr_o),
  .dat_i      (wb_dat_o)
);

`default_nettype wire

// ==== testbench/tb_backend.sv ====
// Testbench for the back end that issues instructions and answers Wishbone cycles from a model
// Register and memory contents are compared against a reference model of accepted instructions
`timescale 1ns/1ps
`default_nettype none

module tb_backend import backend_pkg::*; ();

  localparam int unsigned CLK_PERIOD  = 100;
  localparam int unsigned DRIVE_DELAY = 10;
  localparam int unsigned TIMEOUT     = 50;
  localparam int unsigned MEM_WORDS   = 64;
  localparam int unsigned SEED        = 32'h2d98d0bc;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              issue_valid_i;
  logic              issue_ready_o;
  wb_instr_type_e    issue_type_i;
  addr_t             issue_pc_i;
  reg_addr_t         issue_rd_i;
  data_t             issue_result_i;
  logic              issue_rd_we_i;
  addr_t             issue_addr_i;
  data_t             issue_store_data_i;
  logic              wb_cyc_o;
  logic              wb_stb_o;
  logic              wb_we_o;
  addr_t             wb_adr_o;
  data_t             wb_dat_o;
  logic [XLEN/8-1:0] wb_sel_o;
  data_t             wb_dat_i;
  logic              wb_ack_i;
  logic              instr_done_o;
  addr_t             pc_wb_o;
  logic              outstanding_load_o;
  logic              outstanding_store_o;
  reg_addr_t         rf_raddr_i;
  data_t             rf_rdata_o;

  // Stimulus and wait states draw from separate streams so process order does not matter
  integer seed      = SEED;
  integer wait_seed = SEED;

  // Reference state, built from accepted instructions only
  data_t ref_regs [NUM_REGS];
  data_t ref_mem  [MEM_WORDS];
  // Storage of the Wishbone slave model
  data_t mem      [MEM_WORDS];

  // Expected retirement order and expected bus accesses
  addr_t exp_pc_q  [$];
  logic  exp_we_q  [$];
  addr_t exp_adr_q [$];
  data_t exp_dat_q [$];

  addr_t       next_pc;
  int unsigned stored_idx [8];

  backend_top UUT (.*);

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // Initial memory word, built from the full byte address of the word
  function automatic data_t fill_word(input int unsigned idx);
    return data_t'(32'hc0de_0000 | (idx << 2));
  endfunction

  // Updates the reference register file and memory for one accepted instruction
  // A load writes its destination whatever rd_we says, a store never writes a register
  function automatic void model_accept(input wb_instr_type_e kind, input reg_addr_t rd,
                                       input data_t result, input logic rd_we,
                                       input addr_t addr, input data_t sdata);
    case (kind)
      WB_INSTR_STORE: ref_mem[addr[7:2]] = sdata;
      WB_INSTR_LOAD: begin
        if (rd != '0) begin
          ref_regs[rd] = ref_mem[addr[7:2]];
        end
      end
      default: begin
        if (rd_we && (rd != '0)) begin
          ref_regs[rd] = result;
        end
      end
    endcase
  endfunction

  task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                             input logic [XLEN-1:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      $display("Regression failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic fail_run(input string what);
    $display("Error: %s", what);
    $display("Regression failed");
    $fatal(1, "Stopped on a failure");
  endtask

  // Presents one instruction and holds it until the edge that accepts it
  // Called just after a rising edge and returns just after the accepting edge
  task automatic issue(input wb_instr_type_e kind, input reg_addr_t rd, input data_t result,
                       input logic rd_we, input addr_t addr, input data_t sdata,
                       output int unsigned stalls);
    stalls             = 0;
    issue_valid_i      = 1'b1;
    issue_type_i       = kind;
    issue_pc_i         = next_pc;
    issue_rd_i         = rd;
    issue_result_i     = result;
    issue_rd_we_i      = rd_we;
    issue_addr_i       = addr;
    issue_store_data_i = sdata;
    @(negedge clk_i);
    while (!issue_ready_o) begin
      stalls++;
      if (stalls > TIMEOUT) begin
        fail_run("issue_ready_o never rose for a pending instruction");
      end
      @(negedge clk_i);
    end
    // Ready is high mid cycle, so the coming edge takes the instruction
    exp_pc_q.push_back(next_pc);
    if (kind != WB_INSTR_OTHER) begin
      exp_we_q.push_back(kind == WB_INSTR_STORE);
      exp_adr_q.push_back(addr);
      exp_dat_q.push_back(sdata);
    end
    model_accept(kind, rd, result, rd_we, addr, sdata);
    next_pc = next_pc + 4;
    @(posedge clk_i);
    #DRIVE_DELAY;
    issue_valid_i = 1'b0;
  endtask

  // Follows a memory instruction through its bus cycle up to the done pulse
  task automatic wait_retire(input logic is_load);
    int unsigned cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!instr_done_o) begin
      check_value("issue_ready_o", issue_ready_o, 1'b0);
      check_value("outstanding_load_o", outstanding_load_o, is_load);
      check_value("outstanding_store_o", outstanding_store_o, !is_load);
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_run("instr_done_o never came for a load or store");
      end
      @(negedge clk_i);
    end
    // The flags still hold in the ack cycle and ready opens for the next one
    check_value("issue_ready_o", issue_ready_o, 1'b1);
    check_value("outstanding_load_o", outstanding_load_o, is_load);
    check_value("outstanding_store_o", outstanding_store_o, !is_load);
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  // Waits until every accepted instruction has retired and its write has landed
  task automatic wait_drain();
    int unsigned cycles;
    cycles = 0;
    while (exp_pc_q.size() != 0) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        fail_run("accepted instructions never all retired");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  task automatic check_registers();
    for (int r = 0; r < NUM_REGS; r++) begin
      rf_raddr_i = reg_addr_t'(r);
      @(negedge clk_i);
      check_value($sformatf("rf_rdata_o x%0d", r), rf_rdata_o, ref_regs[r]);
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
  endtask

  task automatic check_memory();
    for (int i = 0; i < MEM_WORDS; i++) begin
      check_value($sformatf("mem word %0d", i), mem[i], ref_mem[i]);
    end
  endtask

  // Checks the bus request against the next expected access and acks it
  task automatic answer_access();
    int unsigned idx;
    idx = wb_adr_o[7:2];
    if (exp_adr_q.size() == 0) begin
      fail_run("a Wishbone cycle started with no load or store accepted");
    end else begin
      check_value("wb_we_o", wb_we_o, exp_we_q.pop_front());
      check_value("wb_adr_o", wb_adr_o, exp_adr_q.pop_front());
      check_value("wb_sel_o", wb_sel_o, 4'hf);
      if (wb_we_o) begin
        check_value("wb_dat_o", wb_dat_o, exp_dat_q.pop_front());
        mem[idx] = wb_dat_o;
      end else begin
        void'(exp_dat_q.pop_front());
      end
      wb_dat_i = mem[idx];
      wb_ack_i = 1'b1;
    end
  endtask

  // Wishbone slave memory with 0 to 3 wait states and a single-cycle ack
  initial begin : wb_memory
    int unsigned wait_left;
    logic        busy;
    wait_left = 0;
    busy      = 1'b0;
    wb_ack_i  = 1'b0;
    wb_dat_i  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      if (wb_ack_i) begin
        wb_ack_i = 1'b0;
        busy     = 1'b0;
      end
      // Cyc still high right after an ack means the next access follows at once
      if (wb_cyc_o && wb_stb_o && !busy) begin
        busy      = 1'b1;
        wait_left = $unsigned($random(wait_seed)) % 4;
      end
      if (busy && !wb_ack_i) begin
        if (wait_left == 0) begin
          answer_access();
        end else begin
          wait_left--;
        end
      end
    end
  end

  // Every done pulse must retire the oldest accepted instruction
  initial begin : retire_monitor
    forever begin
      @(negedge clk_i);
      if (rst_ni && instr_done_o) begin
        if (exp_pc_q.size() == 0) begin
          fail_run("instr_done_o pulsed with no accepted instruction in flight");
        end else begin
          check_value("pc_wb_o", pc_wb_o, exp_pc_q.pop_front());
        end
      end
    end
  end

  initial begin : stimulus
    int unsigned    stalls;
    int unsigned    idx;
    int unsigned    gap;
    reg_addr_t      rd;
    logic           rd_we;
    wb_instr_type_e kind;
    rst_ni             = 1'b0;
    issue_valid_i      = 1'b0;
    issue_type_i       = WB_INSTR_OTHER;
    issue_pc_i         = '0;
    issue_rd_i         = '0;
    issue_result_i     = '0;
    issue_rd_we_i      = 1'b0;
    issue_addr_i       = '0;
    issue_store_data_i = '0;
    rf_raddr_i         = '0;
    next_pc            = 32'h0000_1000;
    for (int i = 0; i < NUM_REGS; i++) begin
      ref_regs[i] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
    end
    repeat (10) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;

    // Idle state straight after reset
    @(negedge clk_i);
    check_value("issue_ready_o", issue_ready_o, 1'b1);
    check_value("wb_cyc_o", wb_cyc_o, 1'b0);
    check_value("wb_stb_o", wb_stb_o, 1'b0);
    check_value("instr_done_o", instr_done_o, 1'b0);
    check_value("outstanding_load_o", outstanding_load_o, 1'b0);
    check_value("outstanding_store_o", outstanding_store_o, 1'b0);
    @(posedge clk_i);
    #DRIVE_DELAY;
    check_registers();

    // Plain instructions back to back, every fourth aimed at x0 and a few without a write
    for (int n = 0; n < 24; n++) begin
      rd    = reg_addr_t'($random(seed));
      rd_we = ((n % 5) != 4);
      if ((n % 4) == 3) begin
        rd = '0;
      end
      issue(WB_INSTR_OTHER, rd, data_t'($random(seed)), rd_we, '0, '0, stalls);
      check_value("issue_ready_o stall cycles", stalls, 0);
    end
    wait_drain();
    check_registers();

    // Stores one at a time, the indices are reused by the loads below
    for (int n = 0; n < 8; n++) begin
      idx           = $unsigned($random(seed)) % MEM_WORDS;
      stored_idx[n] = idx;
      issue(WB_INSTR_STORE, reg_addr_t'($random(seed)), '0, 1'b1, addr_t'(idx << 2),
            data_t'($random(seed)), stalls);
      wait_retire(1'b0);
    end
    check_memory();

    // Loads back from the stored words into nonzero registers
    for (int n = 0; n < 8; n++) begin
      rd = reg_addr_t'($random(seed));
      if (rd == '0) begin
        rd = reg_addr_t'(1);
      end
      issue(WB_INSTR_LOAD, rd, data_t'($random(seed)), 1'b1, addr_t'(stored_idx[n] << 2),
            '0, stalls);
      wait_retire(1'b1);
    end
    wait_drain();
    check_registers();

    // Mixed stream with random gaps between issues
    for (int n = 0; n < 64; n++) begin
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) begin
        @(posedge clk_i);
        #DRIVE_DELAY;
      end
      case ($unsigned($random(seed)) % 3)
        0: kind = WB_INSTR_OTHER;
        1: kind = WB_INSTR_LOAD;
        default: kind = WB_INSTR_STORE;
      endcase
      rd    = reg_addr_t'($random(seed));
      rd_we = (kind == WB_INSTR_LOAD) ? 1'b1 : 1'($random(seed));
      idx   = $unsigned($random(seed)) % MEM_WORDS;
      issue(kind, rd, data_t'($random(seed)), rd_we, addr_t'(idx << 2),
            data_t'($random(seed)), stalls);
    end
    wait_drain();
    check_registers();
    check_memory();

    // Every accepted load and store must have been served on the bus
    if (exp_adr_q.size() != 0) begin
      fail_run("accepted loads or stores never appeared on the bus");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/backend_pkg.sv
logic/ex_wb_if.sv
logic/lsu_wishbone.sv
logic/wb_stage.sv
logic/reg_file.sv
logic/backend_top.sv
testbench/backend_assertions.sv
testbench/tb_backend.sv

// ==== Bender.yml ====
package:
  name: wb_backend

sources:
  - logic/backend_pkg.sv
  - logic/ex_wb_if.sv
  - logic/lsu_wishbone.sv
  - logic/wb_stage.sv
  - logic/reg_file.sv
  - logic/backend_top.sv
  - target: test
    files:
      - testbench/backend_assertions.sv
      - testbench/tb_backend.sv
